/* Bender.yml */
package:
  name: f2c_dma

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/f2c_pkg.sv
      - hdl/f2c_stream_fifo.sv
      - hdl/f2c_burst_decode.sv
      - hdl/f2c_dma_execute.sv
      - hdl/f2c_write_result.sv
      - hdl/f2c_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/f2c_chk.sv
      - testbench/f2c_tb.sv

/* flist.f */
+incdir+hdl
hdl/f2c_pkg.sv
hdl/f2c_stream_fifo.sv
hdl/f2c_burst_decode.sv
hdl/f2c_dma_execute.sv
hdl/f2c_write_result.sv
hdl/f2c_top.sv
testbench/f2c_chk.sv
testbench/f2c_tb.sv

/* hdl/f2c_burst_decode.sv */
`timescale 1ns/1ps
`include "f2c_settings.svh"

module f2c_burst_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`F2C_RB_AW:0]     pkt_rb_size,
  input  logic [`F2C_RB_AW:0]     dsc_rb_size,
  input  f2c_pkg::pkt_meta_t      meta,
  input  logic [`F2C_RB_AW-1:0]   cur_tail,
  input  logic [15:0]             cur_size,
  output f2c_pkg::burst_plan_t    plan,
  output logic [63:0]             dsc_addr,
  output logic                    dsc_wen,
  output logic [`F2C_RB_AW-1:0]   next_tail
);

  import f2c_pkg::*;

  logic [`F2C_RB_AW:0]   pkt_size_r;
  logic [`F2C_RB_AW-1:0] pkt_mask_r;
  logic [`F2C_RB_AW-1:0] dsc_mask_r;

  logic [`F2C_RB_AW:0]   slots_left;
  logic [15:0]           len;
  logic                  addr_ok;
  logic [`F2C_RB_AW-1:0] dsc_tail;

  // Ring sizes are powers of two, so size minus one is the wrap mask
  always_ff @(posedge clk) begin
    if (rst) begin
      pkt_size_r <= '0;
      pkt_mask_r <= '0;
      dsc_mask_r <= '0;
    end else begin
      pkt_size_r <= pkt_rb_size;
      pkt_mask_r <= pkt_rb_size[`F2C_RB_AW-1:0] - 1'b1;
      dsc_mask_r <= dsc_rb_size[`F2C_RB_AW-1:0] - 1'b1;
    end
  end

  // Writes are skipped entirely when either ring is not set up
  assign addr_ok = (meta.pkt_q_state.kmem_addr != '0) &&
                   (meta.dsc_q_state.kmem_addr != '0);

  // Slots left before the end of the packet ring
  assign slots_left = pkt_size_r - {1'b0, cur_tail};

  always_comb begin
    len = cur_size;
    if (len > 16'(`F2C_MAX_BURST)) begin
      len = 16'(`F2C_MAX_BURST);
    end
    // A burst never runs past the ring end
    if (len > 16'(slots_left)) begin
      len = 16'(slots_left);
    end
  end

  assign plan.len  = len[3:0];
  assign plan.addr = meta.pkt_q_state.kmem_addr +
                     64'(cur_tail) * 64'(`F2C_FLIT_BYTES);
  assign plan.wen  = addr_ok && !meta.drop_data;

  assign next_tail = (cur_tail + 1'b1) & pkt_mask_r;

  assign dsc_tail = meta.dsc_q_state.tail[`F2C_RB_AW-1:0] & dsc_mask_r;
  assign dsc_addr = meta.dsc_q_state.kmem_addr +
                    64'(dsc_tail) * 64'(`F2C_FLIT_BYTES);
  assign dsc_wen  = addr_ok && meta.needs_dsc && !meta.drop_meta;

endmodule

/* hdl/f2c_dma_execute.sv */
`timescale 1ns/1ps
`include "f2c_settings.svh"

module f2c_dma_execute (
  input  logic                  clk,
  input  logic                  rst,
  input  f2c_pkg::flit_t        flit,
  input  logic                  flit_valid,
  output logic                  flit_ready,
  input  f2c_pkg::pkt_meta_t    meta,
  input  logic                  meta_valid,
  output logic                  meta_ready,
  input  logic                  stall,
  input  f2c_pkg::burst_plan_t  plan,
  input  logic [63:0]           dsc_addr,
  input  logic                  dsc_wen,
  input  logic [`F2C_RB_AW-1:0] next_tail,
  output f2c_pkg::pkt_meta_t    cur_meta,
  output logic [`F2C_RB_AW-1:0] cur_tail,
  output logic [15:0]           cur_size,
  output f2c_pkg::bus_req_t     issue,
  output f2c_pkg::dma_cnt_t     evt
);

  import f2c_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    START_BURST,
    IN_BURST,
    SEND_DSC
  } state_t;

  state_t state;

  pkt_meta_t             meta_r;
  logic [`F2C_RB_AW-1:0] tail_r;
  logic [15:0]           size_r;
  logic [3:0]            burst_left;

  logic       take_flit;
  logic       send_dsc;
  logic [3:0] burst_left_nx;
  logic [15:0] size_nx;
  rx_dsc_t    dsc_beat;

  // Before the first flit the plan is made from the FIFO head metadata
  assign cur_meta = (state == IDLE) ? meta : meta_r;
  assign cur_tail = (state == IDLE) ? meta.pkt_q_state.tail[`F2C_RB_AW-1:0] : tail_r;
  assign cur_size = (state == IDLE) ? meta.size : size_r;

  assign size_nx       = cur_size - 16'd1;
  assign burst_left_nx = (state == IN_BURST) ? burst_left - 4'd1 : plan.len - 4'd1;

  always_comb begin
    take_flit = 1'b0;
    send_dsc  = 1'b0;
    case (state)
      IDLE:        take_flit = flit_valid && meta_valid && !stall;
      START_BURST: take_flit = flit_valid && !stall;
      IN_BURST:    take_flit = flit_valid && !stall;
      SEND_DSC:    send_dsc  = !stall;
      default:     take_flit = 1'b0;
    endcase
  end

  // Metadata leaves its FIFO together with the first flit
  assign flit_ready = take_flit;
  assign meta_ready = take_flit && (state == IDLE);

  // Tail in the descriptor is the packet ring tail after the last flit
  always_comb begin
    dsc_beat          = '0;
    dsc_beat.signal   = 1'b1;
    dsc_beat.tail     = 32'(tail_r);
    dsc_beat.queue_id = 32'(meta_r.pkt_queue_id);
  end

  always_comb begin
    issue = '0;
    evt   = '0;
    if (take_flit) begin
      issue.address   = plan.addr;
      issue.writedata = flit.data;
      // Only the first beat of a burst carries its length
      issue.burstcount = (state == IN_BURST) ? 4'd0 : plan.len;
      issue.write      = plan.wen;
      evt.flit_cnt      = 32'(plan.wen);
      evt.flit_drop_cnt = 32'(!plan.wen);
    end else if (send_dsc) begin
      issue.address    = dsc_addr;
      issue.writedata  = dsc_beat;
      issue.burstcount = 4'd1;
      issue.write      = dsc_wen;
      evt.dsc_cnt      = 32'(dsc_wen);
      evt.dsc_drop_cnt = 32'(!dsc_wen);
    end
  end

  always_ff @(posedge clk) begin
    if (take_flit && (state == IDLE)) begin
      meta_r <= meta;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      tail_r     <= '0;
      size_r     <= '0;
      burst_left <= '0;
    end else if (take_flit) begin
      tail_r     <= next_tail;
      size_r     <= size_nx;
      burst_left <= burst_left_nx;
      if (burst_left_nx != 4'd0) begin
        state <= IN_BURST;
      end else if (size_nx != 16'd0) begin
        state <= START_BURST;
      end else if (cur_meta.needs_dsc) begin
        state <= SEND_DSC;
      end else begin
        state <= IDLE;
      end
    end else if (send_dsc) begin
      state <= IDLE;
    end
  end

endmodule

/* hdl/f2c_pkg.sv */
`include "f2c_settings.svh"

package f2c_pkg;

  // One packet beat
  typedef struct packed {
    logic [`F2C_DATA_W-1:0] data;
    logic                   sop;
    logic                   eop;
  } flit_t;

  // CPU ring location, base address plus tail slot index
  typedef struct packed {
    logic [63:0] kmem_addr;
    logic [31:0] tail;
  } queue_state_t;

  // Per-packet metadata, size counts flits
  typedef struct packed {
    logic [15:0]           size;
    logic [`F2C_QID_W-1:0] pkt_queue_id;
    queue_state_t          pkt_q_state;
    queue_state_t          dsc_q_state;
    logic                  needs_dsc;
    logic                  drop_data;
    logic                  drop_meta;
  } pkt_meta_t;

  // Next burst as planned from the current tail and remaining size
  typedef struct packed {
    logic [3:0]  len;
    logic [63:0] addr;
    logic        wen;
  } burst_plan_t;

  // Avalon-style write master request
  typedef struct packed {
    logic [63:0]            address;
    logic [`F2C_DATA_W-1:0] writedata;
    logic [3:0]             burstcount;
    logic                   write;
  } bus_req_t;

  // Receive descriptor, one full bus beat
  typedef struct packed {
    logic                    signal;
    logic [31:0]             tail;
    logic [31:0]             queue_id;
    logic [`F2C_DATA_W-66:0] pad;
  } rx_dsc_t;

  // DMA counters, also used as per-cycle increments
  typedef struct packed {
    logic [31:0] flit_cnt;
    logic [31:0] flit_drop_cnt;
    logic [31:0] dsc_cnt;
    logic [31:0] dsc_drop_cnt;
  } dma_cnt_t;

endpackage

/* hdl/f2c_settings.svh */
`ifndef F2C_SETTINGS_SVH
`define F2C_SETTINGS_SVH

// Bus and flit data width in bits
`define F2C_DATA_W 512

// Index width of a CPU ring buffer
`define F2C_RB_AW 12

// Queue id width
`define F2C_QID_W 8

// Largest write burst in flits
`define F2C_MAX_BURST 8

// Bytes per flit, which is also the size of one ring slot
`define F2C_FLIT_BYTES 64

// Depth of the packet and metadata input FIFOs
`define F2C_FIFO_DEPTH 16

`endif

/* hdl/f2c_stream_fifo.sv */
`timescale 1ns/1ps

module f2c_stream_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 16
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t   mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic do_push;
  logic do_pop;

  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign do_push = in_valid && in_ready;
  assign do_pop  = out_valid && out_ready;

  // Storage itself is not reset
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count unchanged
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

/* hdl/f2c_top.sv */
`timescale 1ns/1ps
`include "f2c_settings.svh"

module f2c_top (
  input  logic                clk,
  input  logic                rst,
  input  f2c_pkg::flit_t      pkt_in,
  input  logic                pkt_in_valid,
  output logic                pkt_in_ready,
  input  f2c_pkg::pkt_meta_t  meta_in,
  input  logic                meta_in_valid,
  output logic                meta_in_ready,
  input  logic [`F2C_RB_AW:0] pkt_rb_size,
  input  logic [`F2C_RB_AW:0] dsc_rb_size,
  input  logic                waitrequest,
  output f2c_pkg::bus_req_t   bus_req,
  output f2c_pkg::dma_cnt_t   cnt
);

  import f2c_pkg::*;

  flit_t     pkt_head;
  logic      pkt_head_valid;
  logic      pkt_head_ready;
  pkt_meta_t meta_head;
  logic      meta_head_valid;
  logic      meta_head_ready;

  pkt_meta_t             cur_meta;
  logic [`F2C_RB_AW-1:0] cur_tail;
  logic [15:0]           cur_size;
  burst_plan_t           plan;
  logic [63:0]           dsc_addr;
  logic                  dsc_wen;
  logic [`F2C_RB_AW-1:0] next_tail;

  bus_req_t issue;
  dma_cnt_t evt;
  logic     stall;

  // Packet flit buffer
  f2c_stream_fifo #(
    .payload_t (flit_t),
    .DEPTH     (`F2C_FIFO_DEPTH)
  ) pkt_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (pkt_in),
    .in_valid  (pkt_in_valid),
    .in_ready  (pkt_in_ready),
    .out_data  (pkt_head),
    .out_valid (pkt_head_valid),
    .out_ready (pkt_head_ready)
  );

  // Metadata buffer, one entry per packet
  f2c_stream_fifo #(
    .payload_t (pkt_meta_t),
    .DEPTH     (`F2C_FIFO_DEPTH)
  ) meta_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .in_data   (meta_in),
    .in_valid  (meta_in_valid),
    .in_ready  (meta_in_ready),
    .out_data  (meta_head),
    .out_valid (meta_head_valid),
    .out_ready (meta_head_ready)
  );

  f2c_burst_decode decode_i (
    .clk         (clk),
    .rst         (rst),
    .pkt_rb_size (pkt_rb_size),
    .dsc_rb_size (dsc_rb_size),
    .meta        (cur_meta),
    .cur_tail    (cur_tail),
    .cur_size    (cur_size),
    .plan        (plan),
    .dsc_addr    (dsc_addr),
    .dsc_wen     (dsc_wen),
    .next_tail   (next_tail)
  );

  f2c_dma_execute execute_i (
    .clk        (clk),
    .rst        (rst),
    .flit       (pkt_head),
    .flit_valid (pkt_head_valid),
    .flit_ready (pkt_head_ready),
    .meta       (meta_head),
    .meta_valid (meta_head_valid),
    .meta_ready (meta_head_ready),
    .stall      (stall),
    .plan       (plan),
    .dsc_addr   (dsc_addr),
    .dsc_wen    (dsc_wen),
    .next_tail  (next_tail),
    .cur_meta   (cur_meta),
    .cur_tail   (cur_tail),
    .cur_size   (cur_size),
    .issue      (issue),
    .evt        (evt)
  );

  f2c_write_result result_i (
    .clk         (clk),
    .rst         (rst),
    .waitrequest (waitrequest),
    .issue       (issue),
    .evt         (evt),
    .stall       (stall),
    .bus_req     (bus_req),
    .cnt         (cnt)
  );

endmodule

/* hdl/f2c_write_result.sv */
`timescale 1ns/1ps

module f2c_write_result (
  input  logic              clk,
  input  logic              rst,
  input  logic              waitrequest,
  input  f2c_pkg::bus_req_t issue,
  input  f2c_pkg::dma_cnt_t evt,
  output logic              stall,
  output f2c_pkg::bus_req_t bus_req,
  output f2c_pkg::dma_cnt_t cnt
);

  import f2c_pkg::*;

  // A pending write must stay on the bus until waitrequest drops
  assign stall = bus_req.write && waitrequest;

  always_ff @(posedge clk) begin
    if (rst) begin
      bus_req.write <= 1'b0;
    end else if (!stall) begin
      bus_req <= issue;
    end
  end

  // Each event field is the increment for the matching counter
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else begin
      cnt.flit_cnt      <= cnt.flit_cnt + evt.flit_cnt;
      cnt.flit_drop_cnt <= cnt.flit_drop_cnt + evt.flit_drop_cnt;
      cnt.dsc_cnt       <= cnt.dsc_cnt + evt.dsc_cnt;
      cnt.dsc_drop_cnt  <= cnt.dsc_drop_cnt + evt.dsc_drop_cnt;
    end
  end

endmodule

/* testbench/f2c_chk.sv */
`timescale 1ns/1ps
`include "f2c_settings.svh"

module f2c_chk (
  input logic              clk,
  input logic              rst,
  input f2c_pkg::bus_req_t bus_req,
  input logic              waitrequest,
  input logic              pkt_in_valid,
  input logic              pkt_in_ready,
  input logic              meta_in_valid,
  input logic              meta_in_ready
);

  int fail_cnt = 0;

  // A write held by waitrequest stays on the bus unchanged
  hold_under_wait: assert property (@(posedge clk) disable iff (rst)
    bus_req.write && waitrequest |=> $stable(bus_req))
    else begin
      $error("bus_req changed while a write was held by waitrequest");
      fail_cnt++;
    end

  burst_limit: assert property (@(posedge clk) disable iff (rst)
    bus_req.write |-> bus_req.burstcount <= `F2C_MAX_BURST)
    else begin
      $error("burstcount %0d above the burst limit", bus_req.burstcount);
      fail_cnt++;
    end

  // Sources only raise valid while the FIFO has room
  pkt_valid_ready: assert property (@(posedge clk) disable iff (rst)
    !(pkt_in_valid && !pkt_in_ready))
    else begin
      $error("pkt_in_valid high while pkt_in_ready is low");
      fail_cnt++;
    end

  meta_valid_ready: assert property (@(posedge clk) disable iff (rst)
    !(meta_in_valid && !meta_in_ready))
    else begin
      $error("meta_in_valid high while meta_in_ready is low");
      fail_cnt++;
    end

endmodule

bind f2c_top f2c_chk chk_i (
  .clk           (clk),
  .rst           (rst),
  .bus_req       (bus_req),
  .waitrequest   (waitrequest),
  .pkt_in_valid  (pkt_in_valid),
  .pkt_in_ready  (pkt_in_ready),
  .meta_in_valid (meta_in_valid),
  .meta_in_ready (meta_in_ready)
);

/* testbench/f2c_tb.sv */
`timescale 1ns/1ps
`include "f2c_settings.svh"

module f2c_tb;

  import f2c_pkg::*;

  localparam int          PKT_RING = 256;
  localparam int          DSC_RING = 16;
  localparam logic [63:0] PKT_BASE = 64'h0000_0001_0000_0000;
  localparam logic [63:0] DSC_BASE = 64'h0000_0002_0000_0000;

  logic                clk;
  logic                rst;
  flit_t               pkt_in;
  logic                pkt_in_valid;
  logic                pkt_in_ready;
  pkt_meta_t           meta_in;
  logic                meta_in_valid;
  logic                meta_in_ready;
  logic [`F2C_RB_AW:0] pkt_rb_size;
  logic [`F2C_RB_AW:0] dsc_rb_size;
  logic                waitrequest;
  bus_req_t            bus_req;
  dma_cnt_t            cnt;

  bus_req_t    exp_q[$];
  bus_req_t    exp_beat;
  dma_cnt_t    exp_cnt;
  int unsigned cycles;
  int unsigned cycle_limit;
  int          err_cnt;
  int          check_cnt;
  int          test_no;
  int          test_start_err;
  logic        wait_rand;
  integer      seed;
  pkt_meta_t   rand_meta [16];

  f2c_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .pkt_in        (pkt_in),
    .pkt_in_valid  (pkt_in_valid),
    .pkt_in_ready  (pkt_in_ready),
    .meta_in       (meta_in),
    .meta_in_valid (meta_in_valid),
    .meta_in_ready (meta_in_ready),
    .pkt_rb_size   (pkt_rb_size),
    .dsc_rb_size   (dsc_rb_size),
    .waitrequest   (waitrequest),
    .bus_req       (bus_req),
    .cnt           (cnt)
  );

  always #10 clk = ~clk;

  // Flit payload tagged with packet number and flit index
  function automatic logic [`F2C_DATA_W-1:0] flit_data(input int pkt_no, input int idx);
    return {16{16'(pkt_no), 16'(idx)}};
  endfunction

  function automatic pkt_meta_t make_meta(input int size, input int tail,
                                          input int dsc_tail, input int qid);
    pkt_meta_t m;
    m = '0;
    m.size = 16'(size);
    m.pkt_queue_id = qid[`F2C_QID_W-1:0];
    m.pkt_q_state.kmem_addr = PKT_BASE;
    m.pkt_q_state.tail = 32'(tail);
    m.dsc_q_state.kmem_addr = DSC_BASE;
    m.dsc_q_state.tail = 32'(dsc_tail);
    m.needs_dsc = 1'b1;
    return m;
  endfunction

  function automatic pkt_meta_t random_meta(input int qid);
    pkt_meta_t   m;
    int          size;
    int          tail;
    int          dsc_tail;
    logic [31:0] r;
    size = 1 + ({$random(seed)} % 20);
    tail = {$random(seed)} % PKT_RING;
    dsc_tail = {$random(seed)} % DSC_RING;
    r = $random(seed);
    m = make_meta(size, tail, dsc_tail, qid);
    m.needs_dsc = (r[1:0] != 2'd0);
    m.drop_data = (r[4:2] == 3'd0);
    m.drop_meta = (r[7:5] == 3'd0);
    // Now and then a ring that is not set up
    if (r[11:8] == 4'd0) begin
      m.pkt_q_state.kmem_addr = '0;
    end
    if (r[15:12] == 4'd0) begin
      m.dsc_q_state.kmem_addr = '0;
    end
    return m;
  endfunction

  // Reference model: expected bus beats and counter steps for one packet
  function automatic void model_packet(input pkt_meta_t m, input int pkt_no);
    int       tail;
    int       left;
    int       len;
    int       k;
    int       idx;
    logic     ok;
    logic     wen;
    bus_req_t beat;
    rx_dsc_t  dsc;
    tail = m.pkt_q_state.tail;
    left = m.size;
    idx = 0;
    ok = (m.pkt_q_state.kmem_addr != 0) && (m.dsc_q_state.kmem_addr != 0);
    wen = ok && !m.drop_data;
    while (left > 0) begin
      len = (left < `F2C_MAX_BURST) ? left : `F2C_MAX_BURST;
      // Bursts stop at the ring end
      if (len > PKT_RING - tail) begin
        len = PKT_RING - tail;
      end
      for (k = 0; k < len; k++) begin
        if (wen) begin
          beat = '0;
          beat.address = m.pkt_q_state.kmem_addr + 64'(tail) * 64'(`F2C_FLIT_BYTES);
          beat.writedata = flit_data(pkt_no, idx);
          beat.burstcount = (k == 0) ? 4'(len) : 4'd0;
          beat.write = 1'b1;
          exp_q.push_back(beat);
          exp_cnt.flit_cnt += 1;
        end else begin
          exp_cnt.flit_drop_cnt += 1;
        end
        tail = (tail + 1) % PKT_RING;
        left -= 1;
        idx += 1;
        cycle_limit += 40;
      end
    end
    if (m.needs_dsc) begin
      cycle_limit += 40;
      if (ok && !m.drop_meta) begin
        dsc = '0;
        dsc.signal = 1'b1;
        dsc.tail = 32'(tail);
        dsc.queue_id = 32'(m.pkt_queue_id);
        beat = '0;
        beat.address = m.dsc_q_state.kmem_addr +
                       64'(m.dsc_q_state.tail % DSC_RING) * 64'(`F2C_FLIT_BYTES);
        beat.writedata = dsc;
        beat.burstcount = 4'd1;
        beat.write = 1'b1;
        exp_q.push_back(beat);
        exp_cnt.dsc_cnt += 1;
      end else begin
        exp_cnt.dsc_drop_cnt += 1;
      end
    end
  endfunction

  function automatic int unsigned count_sum(input dma_cnt_t c);
    return c.flit_cnt + c.flit_drop_cnt + c.dsc_cnt + c.dsc_drop_cnt;
  endfunction

  // Metadata goes first, then the flits back to back
  task automatic send_packet(input pkt_meta_t m, input int pkt_no);
    int i;
    model_packet(m, pkt_no);
    @(negedge clk);
    while (!meta_in_ready) begin
      @(negedge clk);
    end
    meta_in = m;
    meta_in_valid = 1'b1;
    for (i = 0; i < m.size; i++) begin
      @(negedge clk);
      meta_in_valid = 1'b0;
      while (!pkt_in_ready) begin
        pkt_in_valid = 1'b0;
        @(negedge clk);
      end
      pkt_in.data = flit_data(pkt_no, i);
      pkt_in.sop = (i == 0);
      pkt_in.eop = (i == m.size - 1);
      pkt_in_valid = 1'b1;
    end
    @(negedge clk);
    pkt_in_valid = 1'b0;
  endtask

  task automatic compare_counters();
    check_cnt += 4;
    if (cnt.flit_cnt !== exp_cnt.flit_cnt) begin
      $display("ERR cnt.flit_cnt got %h exp %h", cnt.flit_cnt, exp_cnt.flit_cnt);
      err_cnt += 1;
    end
    if (cnt.flit_drop_cnt !== exp_cnt.flit_drop_cnt) begin
      $display("ERR cnt.flit_drop_cnt got %h exp %h", cnt.flit_drop_cnt, exp_cnt.flit_drop_cnt);
      err_cnt += 1;
    end
    if (cnt.dsc_cnt !== exp_cnt.dsc_cnt) begin
      $display("ERR cnt.dsc_cnt got %h exp %h", cnt.dsc_cnt, exp_cnt.dsc_cnt);
      err_cnt += 1;
    end
    if (cnt.dsc_drop_cnt !== exp_cnt.dsc_drop_cnt) begin
      $display("ERR cnt.dsc_drop_cnt got %h exp %h", cnt.dsc_drop_cnt, exp_cnt.dsc_drop_cnt);
      err_cnt += 1;
    end
  endtask

  // Done once every expected beat is seen and every event is counted
  task automatic finish_test(input string name);
    int errs;
    while (exp_q.size() != 0 || count_sum(cnt) < count_sum(exp_cnt)) begin
      @(negedge clk);
    end
    compare_counters();
    test_no += 1;
    errs = err_cnt + dut_i.chk_i.fail_cnt - test_start_err;
    $display("test %0d (%s) finished with %0d errors", test_no, name, errs);
    test_start_err = err_cnt + dut_i.chk_i.fail_cnt;
  endtask

  always @(negedge clk) begin
    if (wait_rand) begin
      waitrequest = (({$random(seed)} % 4) == 0);
    end else begin
      waitrequest = 1'b0;
    end
  end

  // Bus monitor, a beat is taken on write high with waitrequest low
  always @(posedge clk) begin
    if (!rst && bus_req.write && !waitrequest) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected bus write to address %h when no beat was expected",
                 bus_req.address);
        err_cnt += 1;
      end else begin
        exp_beat = exp_q.pop_front();
        check_cnt += 1;
        if (bus_req.address !== exp_beat.address) begin
          $display("ERR bus_req.address got %h exp %h", bus_req.address, exp_beat.address);
          err_cnt += 1;
        end
        if (bus_req.burstcount !== exp_beat.burstcount) begin
          $display("ERR bus_req.burstcount got %h exp %h",
                   bus_req.burstcount, exp_beat.burstcount);
          err_cnt += 1;
        end
        if (bus_req.writedata !== exp_beat.writedata) begin
          $display("ERR bus_req.writedata got %h exp %h",
                   bus_req.writedata, exp_beat.writedata);
          err_cnt += 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles += 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped writing before all beats came",
               cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    pkt_meta_t m;
    int        i;
    int        total;
    clk = 1'b0;
    rst = 1'b1;
    pkt_in = '0;
    pkt_in_valid = 1'b0;
    meta_in = '0;
    meta_in_valid = 1'b0;
    pkt_rb_size = PKT_RING;
    dsc_rb_size = DSC_RING;
    waitrequest = 1'b0;
    wait_rand = 1'b0;
    seed = 32'h28f0;
    exp_cnt = '0;
    cycles = 0;
    cycle_limit = 500;
    err_cnt = 0;
    check_cnt = 0;
    test_no = 0;
    test_start_err = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    send_packet(make_meta(1, 5, 3, 8'h21), 1);
    finish_test("single flit with descriptor");

    send_packet(make_meta(20, 0, 4, 8'h22), 2);
    finish_test("bursts of 8, 8 and 4");

    send_packet(make_meta(6, PKT_RING - 3, 5, 8'h23), 3);
    finish_test("split at ring end");

    m = make_meta(5, 40, 6, 8'h24);
    m.drop_data = 1'b1;
    send_packet(m, 4);
    m = make_meta(2, 45, 7, 8'h25);
    m.drop_meta = 1'b1;
    send_packet(m, 5);
    finish_test("drop flags");

    m = make_meta(4, 60, 8, 8'h26);
    m.pkt_q_state.kmem_addr = '0;
    send_packet(m, 6);
    finish_test("zero ring address");

    for (i = 0; i < 16; i++) begin
      rand_meta[i] = random_meta(8'h40 + i);
    end
    @(posedge clk);
    wait_rand = 1'b1;
    for (i = 0; i < 16; i++) begin
      send_packet(rand_meta[i], 16 + i);
    end
    finish_test("random mix under waitrequest");
    @(posedge clk);
    wait_rand = 1'b0;

    total = err_cnt + dut_i.chk_i.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors", test_no, check_cnt, total);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
